// File: sdram_pkg.sv
package sdram_pkg;

	// controller states, init sequence first, then normal operation
	typedef enum logic [3:0] {
		start          = 4'd0,  // power-up wait is armed here
		precharge_init = 4'd1,  // precharge all banks once
		refresh_1      = 4'd2,  // first init auto-refresh
		refresh_2      = 4'd3,  // second init auto-refresh
		load_mode_reg  = 4'd4,  // program burst and cas latency
		idle           = 4'd5,  // waits for a request or a refresh
		activate       = 4'd6,  // opens the latched row
		read_cmd       = 4'd7,  // full-page read from column 0
		read_data      = 4'd8,  // captures the read burst
		write_cmd      = 4'd9,  // full-page write, first word
		write_burst    = 4'd10, // remaining write words
		refresh        = 4'd11, // auto-refresh after precharge-all
		delay          = 4'd12  // counts down, then goes to the saved state
	} sdram_state_e;

	// command word {cs_n, ras_n, cas_n, we_n}
	typedef enum logic [3:0] {
		cmd_nop       = 4'b1111,
		cmd_precharge = 4'b0010, // a10 high selects all banks
		cmd_activate  = 4'b0011,
		cmd_read      = 4'b0101,
		cmd_write     = 4'b0100,
		cmd_setmode   = 4'b0000, // mode word on the address bus
		cmd_refresh   = 4'b0001
	} sdram_cmd_e;

	// minimum spacings in clocks at about 165 MHz
	localparam logic [3:0] t_rp  = 4'd3;  // precharge period
	localparam logic [3:0] t_rc  = 4'd10; // refresh to refresh, activate to activate
	localparam logic [3:0] t_mrd = 4'd2;  // mode register set
	localparam logic [3:0] t_rcd = 4'd3;  // activate to read or write
	localparam logic [3:0] t_wr  = 4'd2;  // write recovery
	localparam logic [3:0] t_cl  = 4'd3;  // cas latency

	localparam logic [15:0] init_wait = 16'd33000;       // about 200 us after power-up
	localparam logic [10:0] refresh_interval = 11'd1125; // a bit under 7.8 us

	localparam logic [9:0] burst_len = 10'd512; // one full page

	// {reserved, write burst, reserved, cl 3, sequential, full page}
	localparam logic [12:0] mode_word = 13'b000_0_00_011_0_111;

	// address bus value for precharge of every bank
	localparam logic [12:0] precharge_all_addr = 13'h0400;

	localparam int addr_w = 15; // row 14:2, bank 1:0
	localparam int data_w = 16;

endpackage

// File: sdram_refresh_timer.sv
`timescale 1ns/1ps

module sdram_refresh_timer
	import sdram_pkg::*;
(
	input  logic clk,
	input  logic rst_n,
	input  logic refresh_ack,  // fsm has started a refresh
	output logic refresh_req   // sticky until acknowledged
);

	logic [10:0] cnt_q; // free-running interval count
	logic        wrap;

	assign wrap = (cnt_q == refresh_interval - 11'd1); // last clock of the interval

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cnt_q       <= '0;
			refresh_req <= 1'b0;
		end else begin
			cnt_q <= wrap ? 11'd0 : cnt_q + 11'd1; // never stops, even in a burst
			if (refresh_ack)
				refresh_req <= 1'b0; // refresh being issued covers this interval
			else if (wrap)
				refresh_req <= 1'b1;
		end
	end

endmodule

// File: sdram_cmd_fsm.sv
`timescale 1ns/1ps

module sdram_cmd_fsm
	import sdram_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              rw,             // 1 read, 0 write
	input  logic              rw_en,          // request strobe, looked at in idle only
	input  logic [addr_w-1:0] f_addr,         // row 14:2, bank 1:0
	input  logic              refresh_req,
	output logic              refresh_ack,    // one clock with the refresh precharge
	output logic              ready,
	output logic              f2s_data_valid, // user must present the next write word
	output logic              wr_take,        // data path registers f2s_data
	output logic              rd_take,        // data path captures s_dq
	output logic              dq_drive,       // data path drives s_dq next clock
	output sdram_cmd_e        cmd,
	output logic [12:0]       s_addr,
	output logic [1:0]        s_ba
);

	sdram_state_e      state_q;
	sdram_state_e      state_d;
	sdram_state_e      nxt_q;       // where delay goes when it runs out
	sdram_state_e      nxt_d;
	sdram_cmd_e        cmd_d;
	logic [15:0]       delay_q;     // long enough for the power-up wait
	logic [15:0]       delay_d;
	logic [9:0]        burst_idx_q; // words moved so far
	logic [9:0]        burst_idx_d;
	logic [12:0]       s_addr_d;
	logic [1:0]        s_ba_d;
	logic              req_q;       // a request is latched and not yet served
	logic              req_d;
	logic              rw_q;
	logic              rw_d;
	logic [addr_w-1:0] addr_q;
	logic [addr_w-1:0] addr_d;

	// delay load for a command-to-command spacing of n clocks
	function automatic logic [15:0] span(input logic [3:0] n);
		return {12'd0, n} - 16'd1;
	endfunction

	assign f2s_data_valid = wr_take; // same strobe toward the user

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state_q     <= start;
			nxt_q       <= start;
			cmd         <= cmd_nop;
			delay_q     <= '0;
			burst_idx_q <= '0;
			s_addr      <= '0;
			s_ba        <= '0;
			req_q       <= 1'b0;
		end else begin
			state_q     <= state_d;
			nxt_q       <= nxt_d;
			cmd         <= cmd_d;   // pins change only on the clock
			delay_q     <= delay_d;
			burst_idx_q <= burst_idx_d;
			s_addr      <= s_addr_d;
			s_ba        <= s_ba_d;
			req_q       <= req_d;
		end
	end

	always_ff @(posedge clk) begin
		rw_q   <= rw_d;   // request direction
		addr_q <= addr_d; // request row and bank
	end

	always_comb begin
		state_d     = state_q;
		nxt_d       = nxt_q;
		cmd_d       = cmd_nop; // nop unless a state issues something
		delay_d     = delay_q;
		burst_idx_d = burst_idx_q;
		s_addr_d    = s_addr;
		s_ba_d      = s_ba;
		req_d       = req_q;
		rw_d        = rw_q;
		addr_d      = addr_q;
		ready       = 1'b0;
		refresh_ack = 1'b0;
		wr_take     = 1'b0;
		rd_take     = 1'b0;
		dq_drive    = 1'b0;
		case (state_q)
			start: begin
				state_d  = delay;
				nxt_d    = precharge_init;
				delay_d  = init_wait; // 200 us power-up wait
				s_addr_d = '0;
				s_ba_d   = '0;
			end
			precharge_init: begin
				state_d  = delay;
				nxt_d    = refresh_1;
				delay_d  = span(t_rp);
				cmd_d    = cmd_precharge;
				s_addr_d = precharge_all_addr;
			end
			refresh_1: begin
				state_d = delay;
				nxt_d   = refresh_2;
				delay_d = span(t_rc);
				cmd_d   = cmd_refresh;
			end
			refresh_2: begin
				state_d = delay;
				nxt_d   = load_mode_reg;
				delay_d = span(t_rc);
				cmd_d   = cmd_refresh;
			end
			load_mode_reg: begin
				state_d  = delay;
				nxt_d    = idle;
				delay_d  = span(t_mrd);
				cmd_d    = cmd_setmode;
				s_addr_d = mode_word;
				s_ba_d   = 2'b00; // reserved bits of the mode set
			end
			idle: begin
				ready = !req_q;
				if (req_q) begin
					state_d = activate; // refresh already done for this request
				end else if (refresh_req || rw_en) begin
					// every access is preceded by a refresh
					state_d     = delay;
					nxt_d       = refresh;
					delay_d     = span(t_rp);
					cmd_d       = cmd_precharge;
					s_addr_d    = precharge_all_addr;
					refresh_ack = 1'b1;
					if (rw_en) begin
						req_d  = 1'b1;
						rw_d   = rw;
						addr_d = f_addr;
					end
				end
			end
			refresh: begin
				state_d = delay;
				nxt_d   = idle;
				delay_d = span(t_rc);
				cmd_d   = cmd_refresh;
			end
			activate: begin
				state_d            = delay;
				nxt_d              = rw_q ? read_cmd : write_cmd;
				delay_d            = span(t_rcd);
				cmd_d              = cmd_activate;
				{s_addr_d, s_ba_d} = addr_q; // row then bank
				burst_idx_d        = '0;
				req_d              = 1'b0;
			end
			read_cmd: begin
				state_d  = delay;
				nxt_d    = read_data;
				delay_d  = {12'd0, t_cl}; // first word sits on s_dq t_cl clocks after the command
				cmd_d    = cmd_read;
				s_addr_d = '0; // column 0, a10 low so no auto precharge
				s_ba_d   = addr_q[1:0];
			end
			read_data: begin
				if (burst_idx_q == burst_len) begin
					state_d  = delay;
					nxt_d    = idle;
					delay_d  = span(t_rp);
					cmd_d    = cmd_precharge; // also stops the full-page burst
					s_addr_d = precharge_all_addr;
				end else begin
					rd_take     = 1'b1;
					burst_idx_d = burst_idx_q + 10'd1;
				end
			end
			write_cmd: begin
				state_d     = write_burst;
				cmd_d       = cmd_write;
				s_addr_d    = '0; // column 0, no auto precharge
				s_ba_d      = addr_q[1:0];
				wr_take     = 1'b1; // word 0 goes out with the command
				dq_drive    = 1'b1;
				burst_idx_d = burst_idx_q + 10'd1;
			end
			write_burst: begin
				if (burst_idx_q == burst_len) begin
					state_d  = delay;
					nxt_d    = idle;
					delay_d  = span(t_rp + t_wr); // precharge plus write recovery
					cmd_d    = cmd_precharge;
					s_addr_d = precharge_all_addr;
				end else begin
					wr_take     = 1'b1;
					dq_drive    = 1'b1;
					burst_idx_d = burst_idx_q + 10'd1;
				end
			end
			delay: begin
				delay_d = delay_q - 16'd1;
				if (delay_q == 16'd1)
					state_d = nxt_q;
			end
			default: state_d = start; // unused codes restart init
		endcase
	end

endmodule

// File: sdram_dq_path.sv
`timescale 1ns/1ps

module sdram_dq_path
	import sdram_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic [data_w-1:0] f2s_data,
	input  logic              wr_take,        // register the user word this clock
	input  logic              rd_take,        // sample the bus this clock
	input  logic              dq_drive,       // drive the bus from next clock on
	inout  wire  [data_w-1:0] s_dq,
	output logic [data_w-1:0] s2f_data,       // held until the next capture
	output logic              s2f_data_valid
);

	logic [data_w-1:0] wr_data_q; // word on the bus during the write
	logic              drive_q;   // lines up with the registered command pins

	always_ff @(posedge clk) begin
		if (wr_take)
			wr_data_q <= f2s_data;
		if (rd_take)
			s2f_data <= s_dq;
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			drive_q        <= 1'b0;
			s2f_data_valid <= 1'b0;
		end else begin
			drive_q        <= dq_drive;
			s2f_data_valid <= rd_take; // valid with the captured word
		end
	end

	// released to high impedance outside the write burst
	assign s_dq = drive_q ? wr_data_q : {data_w{1'bz}};

endmodule

// File: sdram_controller.sv
`timescale 1ns/1ps

module sdram_controller
	import sdram_pkg::*;
(
	input  logic              clk,
	input  logic              rst_n,
	input  logic              rw,             // 1 read, 0 write
	input  logic              rw_en,          // request strobe
	input  logic [addr_w-1:0] f_addr,         // row 14:2, bank 1:0
	input  logic [data_w-1:0] f2s_data,
	output logic [data_w-1:0] s2f_data,
	output logic              s2f_data_valid,
	output logic              f2s_data_valid,
	output logic              ready,
	output logic              s_cs_n,
	output logic              s_ras_n,
	output logic              s_cas_n,
	output logic              s_we_n,
	output logic [12:0]       s_addr,
	output logic [1:0]        s_ba,
	inout  wire  [data_w-1:0] s_dq
);

	logic       refresh_req;
	logic       refresh_ack;
	logic       wr_take;
	logic       rd_take;
	logic       dq_drive;
	sdram_cmd_e cmd;

	assign {s_cs_n, s_ras_n, s_cas_n, s_we_n} = cmd; // registered in the fsm

	sdram_refresh_timer u_timer (
		.clk         (clk),
		.rst_n       (rst_n),
		.refresh_ack (refresh_ack),
		.refresh_req (refresh_req)
	);

	sdram_cmd_fsm u_fsm (
		.clk            (clk),
		.rst_n          (rst_n),
		.rw             (rw),
		.rw_en          (rw_en),
		.f_addr         (f_addr),
		.refresh_req    (refresh_req),
		.refresh_ack    (refresh_ack),
		.ready          (ready),
		.f2s_data_valid (f2s_data_valid),
		.wr_take        (wr_take),
		.rd_take        (rd_take),
		.dq_drive       (dq_drive),
		.cmd            (cmd),
		.s_addr         (s_addr),
		.s_ba           (s_ba)
	);

	sdram_dq_path u_dq (
		.clk            (clk),
		.rst_n          (rst_n),
		.f2s_data       (f2s_data),
		.wr_take        (wr_take),
		.rd_take        (rd_take),
		.dq_drive       (dq_drive),
		.s_dq           (s_dq),
		.s2f_data       (s2f_data),
		.s2f_data_valid (s2f_data_valid)
	);

endmodule

// File: sdram_model.sv
`timescale 1ns/1ps

module sdram_model
	import sdram_pkg::*;
(
	input  logic        clk,
	input  logic        rst_n,
	input  logic        s_cs_n,
	input  logic        s_ras_n,
	input  logic        s_cas_n,
	input  logic        s_we_n,
	input  logic [12:0] s_addr,
	input  logic [1:0]  s_ba,
	inout  wire  [15:0] s_dq,
	output logic        protocol_error, // sticky, any illegal command order
	output logic [12:0] mode_seen       // last mode register load
);

	logic [15:0] mem [bit [23:0]]; // sparse store, {bank, row, column}
	logic [12:0] open_row [4];
	logic [3:0]  row_open;         // one flag per bank
	logic [3:0]  pins;
	logic        wr_active;        // full-page write in progress
	logic [9:0]  wr_col;
	logic        rd_active;
	logic [3:0]  rd_wait;          // cas latency countdown
	logic [9:0]  rd_col;
	logic [1:0]  burst_ba;
	logic        dq_en;
	logic [15:0] dq_out;

	assign pins = {s_cs_n, s_ras_n, s_cas_n, s_we_n};
	assign s_dq = dq_en ? dq_out : 16'hzzzz;

	function automatic logic [23:0] key(input logic [1:0] ba, input logic [12:0] row,
			input logic [9:0] col);
		return {ba, row, col[8:0]};
	endfunction

	// unwritten words read back as a mix of every address bit
	function automatic logic [15:0] read_word(input logic [23:0] k);
		if (mem.exists(k))
			return mem[k];
		return k[15:0] ^ {8'h00, k[23:16]};
	endfunction

	always @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			protocol_error <= 1'b0;
			mode_seen      <= '0;
			row_open       <= 4'b0000;
			wr_active      <= 1'b0;
			wr_col         <= '0;
			rd_active      <= 1'b0;
			rd_wait        <= '0;
			rd_col         <= '0;
			burst_ba       <= '0;
			dq_en          <= 1'b0;
			dq_out         <= '0;
		end else begin
			case (pins)
				cmd_setmode: mode_seen <= s_addr;
				cmd_activate: begin
					if (row_open[s_ba])
						protocol_error <= 1'b1; // bank was never precharged
					open_row[s_ba] <= s_addr;
					row_open[s_ba] <= 1'b1;
				end
				cmd_precharge: begin
					wr_active <= 1'b0; // ends a full-page write
					if (s_addr[10])
						row_open <= 4'b0000;
					else
						row_open[s_ba] <= 1'b0;
				end
				cmd_refresh: begin
					if (row_open != 4'b0000)
						protocol_error <= 1'b1; // refresh needs all banks idle
				end
				cmd_write: begin
					if (!row_open[s_ba])
						protocol_error <= 1'b1; // no activate before the write
					mem[key(s_ba, open_row[s_ba], 10'd0)] = s_dq; // word 0 rides with the command
					wr_active <= 1'b1;
					wr_col    <= 10'd1;
					burst_ba  <= s_ba;
				end
				cmd_read: begin
					if (!row_open[s_ba])
						protocol_error <= 1'b1;
					rd_active <= 1'b1;
					rd_wait   <= t_cl - 4'd1;
					rd_col    <= '0;
					burst_ba  <= s_ba;
				end
				cmd_nop: begin
					if (wr_active && wr_col != 10'd512) begin
						mem[key(burst_ba, open_row[burst_ba], wr_col)] = s_dq;
						wr_col <= wr_col + 10'd1;
					end
				end
				default: protocol_error <= 1'b1; // unknown command word
			endcase
			if (rd_active) begin
				if (rd_wait > 4'd1) begin
					rd_wait <= rd_wait - 4'd1;
				end else if (rd_col == 10'd512) begin
					rd_active <= 1'b0; // page fully read
					dq_en     <= 1'b0;
				end else begin
					dq_en  <= 1'b1;
					dq_out <= read_word(key(burst_ba, open_row[burst_ba], rd_col));
					rd_col <= rd_col + 10'd1;
				end
			end
		end
	end

endmodule

// File: tb_sdram_controller.sv
`timescale 1ns/1ps

module tb_sdram_controller
	import sdram_pkg::*;
();

	localparam int max_cycles = 60000; // init ~33030 plus 8 bursts ~560 plus idle watch ~4600
	localparam int refresh_gap_max = int'(refresh_interval) + int'(t_rp) + int'(t_rc) + 4;

	logic              clk;
	logic              rst_n;
	logic              rw;
	logic              rw_en;
	logic [addr_w-1:0] f_addr;
	logic [data_w-1:0] f2s_data;
	logic [data_w-1:0] s2f_data;
	logic              s2f_data_valid;
	logic              f2s_data_valid;
	logic              ready;
	logic              s_cs_n;
	logic              s_ras_n;
	logic              s_cas_n;
	logic              s_we_n;
	logic [12:0]       s_addr;
	logic [1:0]        s_ba;
	wire  [data_w-1:0] s_dq;
	logic              protocol_error;
	logic [12:0]       mode_seen;

	int          cycles = 0;
	int          errors = 0;
	int          tests_run = 0;
	int          tests_failed = 0;
	logic [15:0] wr_words [512];  // words the user hands over in a write
	logic [15:0] exp_words [512]; // expected readback
	logic [15:0] pat_a [512];
	logic [15:0] pat_b [512];

	sdram_controller dut0 (
		.clk(clk), .rst_n(rst_n), .rw(rw), .rw_en(rw_en), .f_addr(f_addr),
		.f2s_data(f2s_data), .s2f_data(s2f_data), .s2f_data_valid(s2f_data_valid),
		.f2s_data_valid(f2s_data_valid), .ready(ready), .s_cs_n(s_cs_n),
		.s_ras_n(s_ras_n), .s_cas_n(s_cas_n), .s_we_n(s_we_n), .s_addr(s_addr),
		.s_ba(s_ba), .s_dq(s_dq)
	);

	sdram_model mem0 (
		.clk(clk), .rst_n(rst_n), .s_cs_n(s_cs_n), .s_ras_n(s_ras_n),
		.s_cas_n(s_cas_n), .s_we_n(s_we_n), .s_addr(s_addr), .s_ba(s_ba),
		.s_dq(s_dq), .protocol_error(protocol_error), .mode_seen(mode_seen)
	);

	initial clk = 1'b0;
	always #50 clk = ~clk; // 100 ns period

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= max_cycles) begin
			$display("timeout after %0d cycles, the DUT stopped making progress", cycles);
			$display("Test FAILED");
			$finish;
		end
	end

	task automatic check_value(input string sig, input logic [31:0] expected,
			input logic [31:0] actual);
		assert (actual === expected) else begin
			$display("error %s expected %h got %h", sig, expected, actual);
			errors++;
		end
	endtask

	task automatic report_test(input string name, input int err_before);
		tests_run++;
		if (errors == err_before) begin
			$display("%s: pass", name);
		end else begin
			tests_failed++;
			$display("%s: fail, %0d errors", name, errors - err_before);
		end
	endtask

	// one full-page access with the strobe held until idle takes it
	task automatic run_access(input logic is_read, input logic [addr_w-1:0] addr,
			input logic extra_strobe);
		int wr_cnt;
		int rd_cnt;
		logic done;
		logic [3:0] pins;
		wr_cnt = 0;
		rd_cnt = 0;
		done = 1'b0;
		@(posedge clk);
		rw       <= is_read;
		f_addr   <= addr;
		f2s_data <= wr_words[0]; // word 0 waits for the first valid
		rw_en    <= 1'b1;
		@(posedge clk);
		while (!ready)
			@(posedge clk);
		rw_en <= 1'b0; // taken at this edge
		while (!done) begin
			@(posedge clk);
			pins = {s_cs_n, s_ras_n, s_cas_n, s_we_n};
			if (pins == cmd_activate) begin
				check_value("s_addr at activate", 32'(addr[14:2]), 32'(s_addr)); // row
				check_value("s_ba at activate", 32'(addr[1:0]), 32'(s_ba));
			end
			if (pins == cmd_read || pins == cmd_write) begin
				check_value("s_addr at read or write", 32'd0, 32'(s_addr)); // column 0, a10 low
				check_value("s_ba at read or write", 32'(addr[1:0]), 32'(s_ba));
			end
			if (f2s_data_valid) begin
				wr_cnt++;
				if (wr_cnt < 512)
					f2s_data <= wr_words[wr_cnt];
			end
			if (s2f_data_valid) begin
				if (rd_cnt < 512)
					check_value("s2f_data", 32'(exp_words[rd_cnt]), 32'(s2f_data));
				rd_cnt++;
			end
			rw_en <= extra_strobe && (wr_cnt + rd_cnt == 100); // stray strobe mid-burst
			if (ready) begin
				done = 1'b1;
				assert (wr_cnt + rd_cnt >= 512) else begin
					$display("ready rose again before the burst had finished");
					errors++;
				end
			end
		end
		check_value(is_read ? "s2f_data_valid count" : "f2s_data_valid count",
			32'd512, 32'(is_read ? rd_cnt : wr_cnt));
		check_value("valid count of the other direction", 32'd0,
			32'(is_read ? wr_cnt : rd_cnt));
		check_value("protocol_error", 32'd0, 32'(protocol_error));
	endtask

	task automatic init_sequence();
		int          err0;
		logic [3:0]  seen [$];
		logic [12:0] addrs [$];
		logic [3:0]  pins;
		logic [3:0]  exp_cmds [4];
		err0 = errors;
		exp_cmds = '{cmd_precharge, cmd_refresh, cmd_refresh, cmd_setmode};
		check_value("ready after reset", 32'd0, 32'(ready));
		check_value("f2s_data_valid after reset", 32'd0, 32'(f2s_data_valid));
		check_value("s2f_data_valid after reset", 32'd0, 32'(s2f_data_valid));
		check_value("command after reset", 32'(cmd_nop),
			32'({s_cs_n, s_ras_n, s_cas_n, s_we_n}));
		while (!ready) begin
			@(posedge clk);
			pins = {s_cs_n, s_ras_n, s_cas_n, s_we_n};
			if (pins != cmd_nop) begin
				seen.push_back(pins);
				addrs.push_back(s_addr);
			end
		end
		check_value("init command count", 32'd4, 32'(seen.size()));
		if (seen.size() == 4) begin
			for (int i = 0; i < 4; i++)
				check_value("init command", 32'(exp_cmds[i]), 32'(seen[i]));
			check_value("s_addr[10] at precharge", 32'd1, 32'(addrs[0][10]));
			check_value("s_addr at setmode", 32'(mode_word), 32'(addrs[3]));
		end
		check_value("mode_seen", 32'(mode_word), 32'(mode_seen));
		report_test("init_sequence", err0);
	endtask

	task automatic write_then_read();
		int err0;
		err0 = errors;
		for (int i = 0; i < 512; i++)
			pat_a[i] = 16'($urandom);
		wr_words = pat_a;
		run_access(1'b0, {13'h0123, 2'd1}, 1'b0);
		exp_words = pat_a;
		run_access(1'b1, {13'h0123, 2'd1}, 1'b0);
		report_test("write_then_read", err0);
	endtask

	task automatic bank_row_independence();
		int err0;
		err0 = errors;
		for (int i = 0; i < 512; i++) begin
			pat_a[i] = 16'($urandom);
			pat_b[i] = 16'($urandom);
		end
		wr_words = pat_a;
		run_access(1'b0, {13'h1a5c, 2'd2}, 1'b0);
		wr_words = pat_b;
		run_access(1'b0, {13'h0007, 2'd3}, 1'b0);
		exp_words = pat_a;
		run_access(1'b1, {13'h1a5c, 2'd2}, 1'b0);
		exp_words = pat_b;
		run_access(1'b1, {13'h0007, 2'd3}, 1'b0);
		report_test("bank_row_independence", err0);
	endtask

	task automatic request_handling();
		int err0;
		err0 = errors;
		wr_words = pat_b;
		run_access(1'b0, {13'h0999, 2'd0}, 1'b1);
		exp_words = pat_b;
		run_access(1'b1, {13'h0999, 2'd0}, 1'b1);
		// a latched stray strobe would start a burst well inside this window
		repeat (40) begin
			@(posedge clk);
			assert (!f2s_data_valid && !s2f_data_valid) else begin
				$display("an extra access started after a strobe given during a burst");
				errors++;
			end
		end
		check_value("protocol_error", 32'd0, 32'(protocol_error));
		report_test("request_handling", err0);
	endtask

	task automatic idle_refresh();
		int err0;
		int gap;
		int seen;
		int limit;
		err0 = errors;
		gap = 0;
		seen = 0;
		limit = 2 * refresh_gap_max; // last refresh before the watch is unknown
		while (seen < 3 && gap <= limit) begin
			@(posedge clk);
			gap++;
			if ({s_cs_n, s_ras_n, s_cas_n, s_we_n} == cmd_refresh) begin
				if (seen > 0) begin
					assert (gap <= refresh_gap_max) else begin
						$display("refresh gap of %0d cycles exceeds %0d", gap, refresh_gap_max);
						errors++;
					end
				end
				seen++;
				gap = 0;
				limit = refresh_gap_max;
			end
		end
		assert (seen == 3) else begin
			$display("no refresh command for %0d cycles while idle", gap);
			errors++;
		end
		report_test("idle_refresh", err0);
	endtask

	initial begin
		void'($urandom(32'h86ae));
		rst_n    = 1'b0;
		rw       = 1'b0;
		rw_en    = 1'b0;
		f_addr   = '0;
		f2s_data = '0;
		repeat (2) @(posedge clk);
		rst_n <= 1'b1;
		init_sequence();
		write_then_read();
		bank_row_independence();
		request_handling();
		idle_refresh();
		$display("tests %0d, passed %0d, failed %0d, errors %0d",
			tests_run, tests_run - tests_failed, tests_failed, errors);
		if (errors == 0) begin
			$display("Test OK");
		end else begin
			$display("Test FAILED");
		end
		$finish;
	end

endmodule

// File: flist.f
sdram_pkg.sv
sdram_refresh_timer.sv
sdram_cmd_fsm.sv
sdram_dq_path.sv
sdram_controller.sv
sdram_model.sv
tb_sdram_controller.sv

// File: Makefile
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       ?= tb_sdram_controller
FLIST     ?= flist.f
OBJ_DIR   ?= obj_dir

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST) -Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "Test OK"

clean:
	rm -rf $(OBJ_DIR)
